//--- source/modexp_pkg.sv
// modular exponentiation shared types
`default_nettype none

package modexp_pkg;

    localparam int WORD_W = 16;  // operand word width

    typedef logic [WORD_W-1:0] word_t;

    // exponent sequencer phases
    typedef enum logic [2:0] {
        exp_idle,
        exp_to_mont,
        exp_find_msb,
        exp_square,
        exp_multiply,
        exp_from_mont,
        exp_handoff
    } exp_phase_t;

    // Montgomery product steps
    typedef enum logic [3:0] {
        mont_idle,
        mont_accum,
        mont_top_carry,
        mont_quotient,
        mont_reduce,
        mont_reduce_top,
        mont_reduce_carry,
        mont_subtract,
        mont_done
    } mont_phase_t;

endpackage

`default_nettype wire

//--- source/mont_if.sv
// sequencer to Montgomery engine link
`timescale 1ns/100ps
`default_nettype none

interface mont_if #(
    parameter int NUM_WORDS = 4
);
    import modexp_pkg::*;

    logic  start;               // only while ready
    logic  ready;
    logic  done;                // one cycle, result valid
    word_t a [NUM_WORDS];
    word_t b [NUM_WORDS];
    word_t result [NUM_WORDS];  // held until next start

    modport seq (
        output start, a, b,
        input  ready, done, result
    );

    modport eng (
        input  start, a, b,
        output ready, done, result
    );

endinterface

`default_nettype wire

//--- source/word_mul_add.sv
// registered word multiply-accumulate
`timescale 1ns/100ps
`default_nettype none

module word_mul_add (
    input  logic              clk,
    input  modexp_pkg::word_t x,
    input  modexp_pkg::word_t y,
    input  modexp_pkg::word_t z,
    input  modexp_pkg::word_t carry_in,
    output modexp_pkg::word_t sum,
    output modexp_pkg::word_t carry_out
);
    import modexp_pkg::*;

    logic [2*WORD_W:0] wide;  // one spare bit to catch overflow

    assign wide = x * y + z + carry_in;

    always_ff @(posedge clk) begin
        sum       <= wide[WORD_W-1:0];
        carry_out <= wide[2*WORD_W-1:WORD_W];
    end

    // x*y + z + c tops out at exactly 2^(2w) - 1
    a_two_words : assert property (@(posedge clk) wide[2*WORD_W] == 1'b0);

endmodule

`default_nettype wire

//--- source/mont_mult.sv
// CIOS Montgomery product engine
`timescale 1ns/100ps
`default_nettype none

module mont_mult #(
    parameter int NUM_WORDS = 4
) (
    input  logic              clk,
    input  logic              reset,
    input  modexp_pkg::word_t n [NUM_WORDS],
    input  modexp_pkg::word_t nprime0,
    mont_if.eng               bus
);
    import modexp_pkg::*;

    localparam int IW = $clog2(NUM_WORDS);

    mont_phase_t   phase;
    logic [IW-1:0] i;         // word of a
    logic [IW-1:0] j;         // word of b / n
    logic          cap;       // capture half of a multiplier step
    logic          last_j;
    logic          borrow;
    logic          keep;      // difference is the reduced result
    logic [WORD_W:0] diff;
    word_t         v [NUM_WORDS+2];
    word_t         carry;
    word_t         q;         // quotient word
    word_t         mx, my, mz, mc;
    word_t         sum, carry_out;

    assign last_j    = (j == IW'(NUM_WORDS - 1));
    assign bus.ready = (phase == mont_idle);
    assign bus.done  = (phase == mont_done);
    assign diff      = {1'b0, v[j]} - {1'b0, n[j]} - {{WORD_W{1'b0}}, borrow};
    assign keep      = (v[NUM_WORDS] != '0) || !diff[WORD_W];

    word_mul_add mac_i (
        .clk       (clk),
        .x         (mx),
        .y         (my),
        .z         (mz),
        .carry_in  (mc),
        .sum       (sum),
        .carry_out (carry_out)
    );

    always_comb begin
        mx = '0;
        my = '0;
        mz = '0;
        mc = carry;
        case (phase)
            mont_accum: begin
                mx = bus.a[i];
                my = bus.b[j];
                mz = v[j];
                mc = (j == '0) ? '0 : carry;  // each pass starts carry-free
            end
            mont_top_carry,
            mont_reduce_top:   mz = v[NUM_WORDS];
            mont_quotient: begin
                mx = v[0];
                my = nprime0;
                mc = '0;
            end
            mont_reduce: begin
                mx = q;
                my = n[j];
                mz = v[j];
                mc = (j == '0) ? '0 : carry;
            end
            mont_reduce_carry: mz = v[NUM_WORDS+1];
            default:           mc = '0;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            phase <= mont_idle;
            i     <= '0;
            j     <= '0;
            cap   <= 1'b0;
        end else begin
            case (phase)
                mont_idle: if (bus.start) phase <= mont_accum;
                mont_subtract: begin
                    j <= last_j ? '0 : j + 1'b1;
                    if (last_j) phase <= mont_done;
                end
                mont_done: phase <= mont_idle;
                default: begin
                    cap <= ~cap;
                    if (cap) begin
                        case (phase)
                            mont_accum, mont_reduce: begin
                                j <= last_j ? '0 : j + 1'b1;
                                if (last_j && phase == mont_accum) phase <= mont_top_carry;
                                if (last_j && phase == mont_reduce) phase <= mont_reduce_top;
                            end
                            mont_top_carry:  phase <= mont_quotient;
                            mont_quotient:   phase <= mont_reduce;
                            mont_reduce_top: phase <= mont_reduce_carry;
                            default: begin  // last carry fix closes word i
                                i     <= (i == IW'(NUM_WORDS - 1)) ? '0 : i + 1'b1;
                                phase <= (i == IW'(NUM_WORDS - 1)) ? mont_subtract : mont_accum;
                            end
                        endcase
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (phase == mont_idle && bus.start) begin
            for (int k = 0; k < NUM_WORDS + 2; k++) v[k] <= '0;
            borrow <= 1'b0;
        end
        if (cap) begin
            case (phase)
                mont_accum:      v[j] <= sum;
                mont_top_carry: begin
                    v[NUM_WORDS]   <= sum;
                    v[NUM_WORDS+1] <= carry_out;
                end
                mont_quotient:   q <= sum;
                mont_reduce:     if (j != '0) v[j-1'b1] <= sum;  // shift down a word
                mont_reduce_top: v[NUM_WORDS-1] <= sum;
                default:         v[NUM_WORDS] <= sum;            // last carry fix
            endcase
            carry <= carry_out;
        end
        if (phase == mont_subtract) begin
            borrow <= diff[WORD_W];
            if (!last_j || keep) bus.result[j] <= diff[WORD_W-1:0];
            else for (int k = 0; k < NUM_WORDS; k++) bus.result[k] <= v[k];
        end
    end

    a_start_when_ready : assert property (
        @(posedge clk) disable iff (reset) bus.start |-> bus.ready
    );

endmodule

`default_nettype wire

//--- source/exp_sequencer.sv
// left-to-right square-and-multiply sequencer
`timescale 1ns/100ps
`default_nettype none

module exp_sequencer #(
    parameter int NUM_WORDS = 4
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              ops_valid,
    input  modexp_pkg::word_t m [NUM_WORDS],
    input  modexp_pkg::word_t e [NUM_WORDS],
    input  modexp_pkg::word_t r [NUM_WORDS],
    input  modexp_pkg::word_t t [NUM_WORDS],
    output logic              job_taken,
    output logic              res_valid,
    input  logic              res_ready,
    output modexp_pkg::word_t res [NUM_WORDS],
    mont_if.seq               bus
);
    import modexp_pkg::*;

    localparam int BITS = NUM_WORDS * WORD_W;
    localparam int BW   = $clog2(BITS);

    exp_phase_t      phase;
    logic            started;   // product in flight
    logic [BW-1:0]   bit_idx;
    logic            e_bit;
    logic            last_bit;
    logic [BITS-1:0] e_bits;
    logic [BITS-1:0] res_flat;
    word_t           m_bar [NUM_WORDS];  // holds m until converted
    word_t           c_bar [NUM_WORDS];

    assign e_bit     = e_bits[bit_idx];
    assign last_bit  = (bit_idx == '0);
    assign res_valid = (phase == exp_handoff);
    assign bus.start = (phase inside {exp_to_mont, exp_square, exp_multiply, exp_from_mont})
                       && !started && bus.ready;

    always_comb begin
        for (int k = 0; k < NUM_WORDS; k++) begin
            case (phase)
                exp_to_mont: begin
                    bus.a[k] = m_bar[k];
                    bus.b[k] = t[k];       // R^2 mod n
                end
                exp_multiply: begin
                    bus.a[k] = c_bar[k];
                    bus.b[k] = m_bar[k];
                end
                exp_from_mont: begin
                    bus.a[k] = (k == 0) ? word_t'(1) : '0;
                    bus.b[k] = c_bar[k];
                end
                default: begin             // squaring
                    bus.a[k] = c_bar[k];
                    bus.b[k] = c_bar[k];
                end
            endcase
            res[k] = c_bar[k];
            res_flat[k*WORD_W +: WORD_W] = c_bar[k];
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            phase     <= exp_idle;
            started   <= 1'b0;
            job_taken <= 1'b0;
            bit_idx   <= '0;
        end else begin
            job_taken <= 1'b0;
            if (bus.start) started <= 1'b1;
            if (bus.done) started <= 1'b0;
            case (phase)
                exp_idle: if (ops_valid) phase <= exp_to_mont;
                exp_to_mont: if (bus.done) begin
                    phase   <= exp_find_msb;
                    bit_idx <= BW'(BITS - 1);
                end
                exp_find_msb: begin
                    if (e_bit) phase <= exp_square;
                    else bit_idx <= bit_idx - 1'b1;
                end
                exp_square, exp_multiply: if (bus.done) begin
                    if (phase == exp_square && e_bit) phase <= exp_multiply;
                    else if (last_bit) phase <= exp_from_mont;
                    else begin
                        bit_idx <= bit_idx - 1'b1;
                        phase   <= exp_square;
                    end
                end
                exp_from_mont: if (bus.done) begin
                    phase     <= exp_handoff;
                    job_taken <= 1'b1;  // n and t no longer needed
                end
                exp_handoff: if (res_ready) phase <= exp_idle;
                default: phase <= exp_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (phase == exp_idle && ops_valid) begin
            for (int k = 0; k < NUM_WORDS; k++) begin
                m_bar[k] <= m[k];
                c_bar[k] <= r[k];  // Montgomery one
                e_bits[k*WORD_W +: WORD_W] <= e[k];
            end
        end
        if (bus.done) begin
            for (int k = 0; k < NUM_WORDS; k++) begin
                if (phase == exp_to_mont) m_bar[k] <= bus.result[k];
                else c_bar[k] <= bus.result[k];
            end
        end
    end

    a_res_hold : assert property (
        @(posedge clk) disable iff (reset)
        res_valid && !res_ready |=> res_valid && $stable(res_flat)
    );

endmodule

`default_nettype wire

//--- source/operand_loader.sv
// word-serial operand loader, one job deep
`timescale 1ns/100ps
`default_nettype none

module operand_loader #(
    parameter int NUM_WORDS = 4
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              in_valid,
    output logic              in_ready,
    input  modexp_pkg::word_t m_word,
    input  modexp_pkg::word_t e_word,
    input  modexp_pkg::word_t n_word,
    input  modexp_pkg::word_t r_word,
    input  modexp_pkg::word_t t_word,
    output logic              ops_valid,
    input  logic              job_taken,
    output modexp_pkg::word_t m [NUM_WORDS],
    output modexp_pkg::word_t e [NUM_WORDS],
    output modexp_pkg::word_t n [NUM_WORDS],
    output modexp_pkg::word_t r [NUM_WORDS],
    output modexp_pkg::word_t t [NUM_WORDS]
);
    import modexp_pkg::*;

    localparam int IW = $clog2(NUM_WORDS);

    logic [IW-1:0] cnt;   // next word slot
    logic          full;
    logic          beat;

    assign beat      = in_valid && in_ready;
    assign in_ready  = ~full;
    assign ops_valid = full;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cnt  <= '0;
            full <= 1'b0;
        end else begin
            if (beat) cnt <= (cnt == IW'(NUM_WORDS - 1)) ? '0 : cnt + 1'b1;
            if (beat && cnt == IW'(NUM_WORDS - 1)) full <= 1'b1;
            if (job_taken) full <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (beat) begin
            m[cnt] <= m_word;
            e[cnt] <= e_word;
            n[cnt] <= n_word;
            r[cnt] <= r_word;
            t[cnt] <= t_word;
        end
    end

endmodule

`default_nettype wire

//--- source/result_unloader.sv
// result buffer and word-serial output
`timescale 1ns/100ps
`default_nettype none

module result_unloader #(
    parameter int NUM_WORDS = 4
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              res_valid,
    output logic              res_ready,
    input  modexp_pkg::word_t res [NUM_WORDS],
    output logic              out_valid,
    input  logic              out_ready,
    output modexp_pkg::word_t out_word,
    output logic              out_last
);
    import modexp_pkg::*;

    localparam int IW = $clog2(NUM_WORDS);

    word_t         hold [NUM_WORDS];
    logic [IW-1:0] cnt;   // word being offered
    logic          busy;

    assign res_ready = ~busy;
    assign out_valid = busy;
    assign out_word  = hold[cnt];
    assign out_last  = (cnt == IW'(NUM_WORDS - 1));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy <= 1'b0;
            cnt  <= '0;
        end else if (res_valid && res_ready) begin
            busy <= 1'b1;
            cnt  <= '0;
        end else if (out_valid && out_ready) begin
            cnt <= out_last ? '0 : cnt + 1'b1;
            if (out_last) busy <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (res_valid && res_ready) hold <= res;
    end

    a_out_hold : assert property (
        @(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out_word) && $stable(out_last)
    );

endmodule

`default_nettype wire

//--- source/modexp_top.sv
// Montgomery modular exponentiation unit
`timescale 1ns/100ps
`default_nettype none

module modexp_top #(
    parameter int NUM_WORDS = 4
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              in_valid,
    output logic              in_ready,
    input  modexp_pkg::word_t m_word,
    input  modexp_pkg::word_t e_word,
    input  modexp_pkg::word_t n_word,
    input  modexp_pkg::word_t r_word,   // R mod n
    input  modexp_pkg::word_t t_word,   // R^2 mod n
    input  modexp_pkg::word_t nprime0,  // -n^-1 mod 2^w
    output logic              out_valid,
    input  logic              out_ready,
    output modexp_pkg::word_t out_word,
    output logic              out_last
);
    import modexp_pkg::*;

    logic  ops_valid;
    logic  job_taken;
    logic  res_valid;
    logic  res_ready;
    word_t m_ops [NUM_WORDS];
    word_t e_ops [NUM_WORDS];
    word_t n_ops [NUM_WORDS];
    word_t r_ops [NUM_WORDS];
    word_t t_ops [NUM_WORDS];
    word_t res [NUM_WORDS];

    mont_if #(.NUM_WORDS(NUM_WORDS)) mont_bus ();

    operand_loader #(.NUM_WORDS(NUM_WORDS)) loader_i (
        .clk(clk), .reset(reset),
        .in_valid(in_valid), .in_ready(in_ready),
        .m_word(m_word), .e_word(e_word), .n_word(n_word),
        .r_word(r_word), .t_word(t_word),
        .ops_valid(ops_valid), .job_taken(job_taken),
        .m(m_ops), .e(e_ops), .n(n_ops), .r(r_ops), .t(t_ops)
    );

    exp_sequencer #(.NUM_WORDS(NUM_WORDS)) seq_i (
        .clk(clk), .reset(reset),
        .ops_valid(ops_valid), .m(m_ops), .e(e_ops), .r(r_ops), .t(t_ops),
        .job_taken(job_taken),
        .res_valid(res_valid), .res_ready(res_ready), .res(res),
        .bus(mont_bus)
    );

    mont_mult #(.NUM_WORDS(NUM_WORDS)) mont_i (
        .clk(clk), .reset(reset),
        .n(n_ops), .nprime0(nprime0),
        .bus(mont_bus)
    );

    result_unloader #(.NUM_WORDS(NUM_WORDS)) unloader_i (
        .clk(clk), .reset(reset),
        .res_valid(res_valid), .res_ready(res_ready), .res(res),
        .out_valid(out_valid), .out_ready(out_ready),
        .out_word(out_word), .out_last(out_last)
    );

endmodule

`default_nettype wire

//--- tests/modexp_tb.sv
// modular exponentiation testbench
`timescale 1ns/100ps
`default_nettype none

module modexp_tb;

    localparam int WORD_W     = 16;
    localparam int NUM_WORDS  = 4;
    localparam int NUM_JOBS   = 12;                // 1 + 3 + 5 + 1 + 2
    localparam int MAX_CYCLES = NUM_JOBS * 20000;  // worst 64-bit exponent fits in 20000

    logic              clk;
    logic              reset;
    logic              in_valid;
    logic              in_ready;
    logic [WORD_W-1:0] m_word;
    logic [WORD_W-1:0] e_word;
    logic [WORD_W-1:0] n_word;
    logic [WORD_W-1:0] r_word;
    logic [WORD_W-1:0] t_word;
    logic [WORD_W-1:0] nprime0;
    logic              out_valid;
    logic              out_ready;
    logic [WORD_W-1:0] out_word;
    logic              out_last;

    int          errors      = 0;
    int          checks      = 0;
    int          cycle_count = 0;
    logic [31:0] lcg_state   = 32'h9f82;

    modexp_top dut_i (
        .clk(clk), .reset(reset),
        .in_valid(in_valid), .in_ready(in_ready),
        .m_word(m_word), .e_word(e_word), .n_word(n_word),
        .r_word(r_word), .t_word(t_word), .nprime0(nprime0),
        .out_valid(out_valid), .out_ready(out_ready),
        .out_word(out_word), .out_last(out_last)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == MAX_CYCLES) begin
            $display("timeout: no finished result after %0d cycles", cycle_count);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    function logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function logic [63:0] random_u64();
        logic [31:0] hi;
        hi = next_random();
        return {hi, next_random()};
    endfunction

    function automatic logic [63:0] mul_mod(input logic [63:0] a, b, n);
        logic [127:0] p;
        p = {64'd0, a} * {64'd0, b};  // full 128-bit product
        return 64'(p % {64'd0, n});
    endfunction

    function automatic logic [63:0] pow_mod(input logic [63:0] m, e, n);
        logic [63:0] acc;
        acc = 64'd1 % n;
        for (int i = 63; i >= 0; i--) begin
            acc = mul_mod(acc, acc, n);
            if (e[i]) acc = mul_mod(acc, m, n);
        end
        return acc;
    endfunction

    // -n^-1 mod 2^16, each Newton step doubles the good bits
    function automatic logic [15:0] neg_inverse(input logic [15:0] n0);
        logic [15:0] inv;
        inv = n0;  // right to 3 bits for odd n
        repeat (4) inv = inv * (16'd2 - n0 * inv);
        return -inv;
    endfunction

    task automatic load_job(input logic [63:0] m, e, n);
        logic [63:0] r;
        logic [63:0] t;
        r = 64'(({64'd1, 64'd0}) % {64'd0, n});  // 2^64 mod n
        t = mul_mod(r, r, n);                    // 2^128 mod n
        for (int k = 0; k < NUM_WORDS; k++) begin
            while (!in_ready) begin
                @(posedge clk);
                #2;
            end
            if (k == 0) nprime0 = neg_inverse(n[15:0]);  // previous job has let go
            m_word   = m[k*WORD_W +: WORD_W];
            e_word   = e[k*WORD_W +: WORD_W];
            n_word   = n[k*WORD_W +: WORD_W];
            r_word   = r[k*WORD_W +: WORD_W];
            t_word   = t[k*WORD_W +: WORD_W];
            in_valid = 1'b1;
            @(posedge clk);
            #2;
        end
        in_valid = 1'b0;
    endtask

    task automatic collect_result(input bit stall, output logic [63:0] value);
        logic [31:0] rnd;
        int          count;
        bit          finished;
        count    = 0;
        finished = 1'b0;
        value    = '0;
        while (!finished) begin
            rnd       = next_random();
            out_ready = stall ? rnd[16] : 1'b1;
            if (out_valid && out_ready) begin
                value[count*WORD_W +: WORD_W] = out_word;
                count++;
                if (out_last) begin
                    finished = 1'b1;
                    if (count != NUM_WORDS) begin
                        $display("result ended after %0d words instead of 4", count);
                        errors++;
                    end
                end else if (count == NUM_WORDS) begin
                    $display("out_last was not raised on the fourth word");
                    errors++;
                    finished = 1'b1;
                end
            end
            @(posedge clk);
            #2;
        end
        out_ready = 1'b0;
    endtask

    task automatic compare_result(input string label, input logic [63:0] got, exp);
        for (int k = 0; k < NUM_WORDS; k++) begin
            checks++;
            if (got[k*WORD_W +: WORD_W] != exp[k*WORD_W +: WORD_W]) begin
                $display("ERR out_word %s word %0d: expected %h, got %h", label, k,
                         exp[k*WORD_W +: WORD_W], got[k*WORD_W +: WORD_W]);
                errors++;
            end
        end
    endtask

    task automatic run_job(input string label, input logic [63:0] m, e, n,
                           input bit stall, input logic [63:0] exp);
        logic [63:0] got;
        load_job(m, e, n);
        collect_result(stall, got);
        compare_result(label, got, exp);
    endtask

    task automatic test_known_case();
        run_job("known case", 64'd5, 64'd3, 64'd185, 1'b0, 64'd125);
    endtask

    task automatic test_exponent_edges();
        logic [63:0] n;
        logic [63:0] m;
        logic [63:0] sq;
        int          shifts [2] = '{5, 63};
        n = random_u64() | 64'h8000_0000_0000_0001;
        m = random_u64() % n;
        run_job("e=1", m, 64'd1, n, 1'b0, m);
        foreach (shifts[s]) begin
            sq = m;
            repeat (shifts[s]) sq = mul_mod(sq, sq, n);  // plain repeated squaring
            run_job("e=2^k", m, 64'd1 << shifts[s], n, 1'b0, sq);
        end
    endtask

    task automatic test_random_jobs();
        logic [63:0] n;
        logic [63:0] m;
        logic [63:0] e;
        repeat (5) begin
            n = random_u64() | 64'h8000_0000_0000_0001;
            m = random_u64() % n;
            e = random_u64();
            if (e == 64'd0) e = 64'd1;  // zero exponent not supported
            run_job("random", m, e, n, 1'b0, pow_mod(m, e, n));
        end
    endtask

    task automatic test_backpressure();
        logic [63:0] n;
        logic [63:0] m;
        logic [63:0] e;
        n = random_u64() | 64'h8000_0000_0000_0001;
        m = random_u64() % n;
        e = random_u64() | 64'd1;
        run_job("stalled", m, e, n, 1'b1, pow_mod(m, e, n));
    endtask

    task automatic test_overlap();
        logic [63:0] n [2];
        logic [63:0] m [2];
        logic [63:0] e [2];
        logic [63:0] got;
        for (int j = 0; j < 2; j++) begin
            n[j] = random_u64() | 64'h8000_0000_0000_0001;
            m[j] = random_u64() % n[j];
            e[j] = random_u64() | 64'd1;
        end
        out_ready = 1'b0;
        load_job(m[0], e[0], n[0]);
        load_job(m[1], e[1], n[1]);  // first result still pending
        while (!out_valid) begin
            @(posedge clk);
            #2;
        end
        collect_result(1'b0, got);
        compare_result("overlap first", got, pow_mod(m[0], e[0], n[0]));
        collect_result(1'b0, got);
        compare_result("overlap second", got, pow_mod(m[1], e[1], n[1]));
    endtask

    initial begin
        reset     = 1'b1;
        in_valid  = 1'b0;
        m_word    = '0;
        e_word    = '0;
        n_word    = '0;
        r_word    = '0;
        t_word    = '0;
        nprime0   = '0;
        out_ready = 1'b0;
        repeat (16) @(posedge clk);
        #2;
        reset = 1'b0;
        test_known_case();
        test_exponent_edges();
        test_random_jobs();
        test_backpressure();
        test_overlap();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- modexp_top.f
source/modexp_pkg.sv
source/mont_if.sv
source/word_mul_add.sv
source/mont_mult.sv
source/exp_sequencer.sv
source/operand_loader.sv
source/result_unloader.sv
source/modexp_top.sv
tests/modexp_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the modexp testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module modexp_tb -f modexp_top.f -o modexp_sim

./obj_dir/modexp_sim > sim.log 2>&1
cat sim.log

if grep -q "SIMULATION FAILED" sim.log; then
    exit 1
fi
exit 0
